// ==== src.f ====
+incdir+tests
logic/nnPkg.sv
logic/neuron.sv
logic/denseLayer.sv
logic/argmaxUnit.sv
logic/mlpClassifier.sv
tests/mlpClassifierTb.sv

// ==== build.sh ====
#!/usr/bin/env bash
# Compile and run the classifier testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module mlpClassifierTb -f src.f -o simv
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
runStatus=$?
cat "$LOG"
if [ $runStatus -ne 0 ]; then
	echo "simulation exited with status $runStatus"
	exit 1
fi

grep -q "ALL TESTS PASSED" "$LOG"
if [ $? -ne 0 ]; then
	echo "simulation failed, see $LOG"
	exit 1
fi

echo "simulation passed"
exit 0

// ==== tests/mlpModel.svh ====
`ifndef MLP_MODEL_SVH
`define MLP_MODEL_SVH

// ReLU, round above half, saturate at the limit.
function automatic int activateSum(input int acc);
	int q;
	int frac;
	if (acc < 0)
		return 0;
	if ((acc >> (nnPkg::FracBits + 7)) != 0)
		return nnPkg::ActMax;
	q = acc >> nnPkg::FracBits;
	frac = acc % (1 << nnPkg::FracBits);
	if (frac > (1 << (nnPkg::FracBits - 1)))
		q = q + 1;
	if (q > nnPkg::ActMax)
		q = nnPkg::ActMax;
	return q;
endfunction

// Activations are bytes read as two's complement.
function automatic int asSigned(input int value);
	if (value > 127)
		return value - 256;
	return value;
endfunction

function automatic void modelScores(input nnPkg::actT sample [nnPkg::NumIn],
	output int scores [nnPkg::NumClass]);
	int hidden [nnPkg::NumHidden];
	int acc;
	for (int n = 0; n < nnPkg::NumHidden; n++)
	begin
		acc = int'(nnPkg::DefHiddenBias[n]);
		for (int i = 0; i < nnPkg::NumIn; i++)
			acc += asSigned(int'(sample[i])) * int'(nnPkg::DefHiddenWeights[n*nnPkg::NumIn + i]);
		hidden[n] = activateSum(acc);
	end
	for (int c = 0; c < nnPkg::NumClass; c++)
	begin
		acc = int'(nnPkg::DefOutBias[c]);
		for (int h = 0; h < nnPkg::NumHidden; h++)
			acc += hidden[h] * int'(nnPkg::DefOutWeights[c*nnPkg::NumHidden + h]);
		scores[c] = activateSum(acc);
	end
endfunction

// Largest score, first index on a tie.
function automatic void pickClass(input int scores [nnPkg::NumClass], output int cls,
	output int best);
	cls = 0;
	best = scores[0];
	for (int c = 1; c < nnPkg::NumClass; c++)
		if (scores[c] > best)
		begin
			cls = c;
			best = scores[c];
		end
endfunction

`endif

// ==== tests/mlpClassifierTb.sv ====
`timescale 1ns/1ps

module mlpClassifierTb;

	`include "mlpModel.svh"

	localparam int ResetCycles = 5;
	localparam int Latency = 7;
	localparam int Test1Count = 24;
	localparam int StallCount = 7;
	localparam int StallHold = 20;
	localparam int DrainCycles = 10;
	localparam int ResetSamples = 3;
	localparam int ResetIdle = 8;
	localparam int StimCycles = 2*ResetCycles + Test1Count + 4 + 2 + StallCount + StallHold
		+ 5 + 5*DrainCycles + ResetSamples + ResetIdle;
	localparam int CycleLimit = 2*StimCycles + 50;

	logic clk;
	logic reset;
	logic inValid;
	logic inReady;
	nnPkg::actT [nnPkg::NumIn-1:0] inAct;
	logic outValid;
	logic outReady;
	nnPkg::classT outClass;
	nnPkg::actT outScore;

	int qClass [$];
	int qScore [$];
	int qCycle [$];
	logic expValid;
	int expClass;
	int expScore;
	int expCycle;
	int cycleCount;
	logic checkLatency;
	int errorCount;
	int errBefore;
	int passCount;
	int failCount;
	integer seed;

	nnPkg::actT seen [nnPkg::NumIn];
	int seenScores [nnPkg::NumClass];
	int seenClass;
	int seenBest;

	mlpClassifier DUT (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inReady(inReady),
		.inAct(inAct),
		.outValid(outValid),
		.outReady(outReady),
		.outClass(outClass),
		.outScore(outScore)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Scoreboard, updated on every edge.
	always @(posedge clk)
	begin
		// Samples in flight are lost on reset.
		if (reset)
		begin
			qClass.delete();
			qScore.delete();
			qCycle.delete();
		end
		if (!reset && outValid && outReady && qClass.size() > 0)
		begin
			void'(qClass.pop_front());
			void'(qScore.pop_front());
			void'(qCycle.pop_front());
		end
		if (!reset && inValid && inReady)
		begin
			for (int i = 0; i < nnPkg::NumIn; i++)
				seen[i] = inAct[i];
			modelScores(seen, seenScores);
			pickClass(seenScores, seenClass, seenBest);
			qClass.push_back(seenClass);
			qScore.push_back(seenBest);
			qCycle.push_back(cycleCount);
		end
		expValid = qClass.size() > 0;
		expClass = expValid ? qClass[0] : 0;
		expScore = expValid ? qScore[0] : 0;
		expCycle = expValid ? qCycle[0] : 0;
		cycleCount = cycleCount + 1;
	end

	outputMatches: assert property (@(posedge clk) disable iff (reset)
		outValid && outReady |-> expValid && outClass == expClass && outScore == expScore)
		else
		begin
			$display("mismatch at %0t: class %0d score %0d, expected class %0d score %0d (queued %0d)",
				$time, $sampled(outClass), $sampled(outScore), $sampled(expClass),
				$sampled(expScore), $sampled(expValid));
			errorCount++;
		end

	latencyMatches: assert property (@(posedge clk) disable iff (reset)
		checkLatency && outValid && outReady |-> cycleCount == expCycle + Latency)
		else
		begin
			$display("mismatch at %0t: output after %0d cycles, expected %0d",
				$time, $sampled(cycleCount) - $sampled(expCycle), Latency);
			errorCount++;
		end

	heldWhileStalled: assert property (@(posedge clk) disable iff (reset)
		outValid && !outReady |=> outValid && $stable(outClass) && $stable(outScore))
		else
		begin
			$display("error at %0t: stalled output changed before it was taken", $time);
			errorCount++;
		end

	quietInReset: assert property (@(posedge clk) reset && $past(reset) |-> !outValid)
		else
		begin
			$display("error at %0t: outValid high during reset", $time);
			errorCount++;
		end

	readyAfterReset: assert property (@(posedge clk) $fell(reset) |-> inReady && !outValid)
		else
		begin
			$display("error at %0t: not ready or not idle on the first cycle after reset", $time);
			errorCount++;
		end

	initial
	begin
		wait (cycleCount >= CycleLimit);
		$display("timeout: run reached %0d cycles without finishing", CycleLimit);
		$display("SOME TESTS FAILED");
		$finish;
	end

	task automatic sendSample(input nnPkg::actT sample [nnPkg::NumIn]);
		logic taken;
		for (int i = 0; i < nnPkg::NumIn; i++)
			inAct[i] = sample[i];
		inValid = 1'b1;
		taken = 1'b0;
		while (!taken)
		begin
			// Let the ready chain settle first.
			#1;
			taken = inReady;
			@(posedge clk);
			#2;
		end
		inValid = 1'b0;
	endtask

	task automatic idleCycles(input int count);
		repeat (count)
		begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic waitDrain();
		while (qClass.size() != 0)
		begin
			@(posedge clk);
			#2;
		end
		idleCycles(2);
	endtask

	task automatic applyReset();
		reset = 1'b1;
		idleCycles(ResetCycles);
		reset = 1'b0;
		idleCycles(1);
	endtask

	task automatic randomSample(input int mask, output nnPkg::actT sample [nnPkg::NumIn]);
		for (int i = 0; i < nnPkg::NumIn; i++)
			sample[i] = nnPkg::actT'($random(seed) & mask);
	endtask

	task automatic reportTest(input string name);
		if (errorCount == errBefore)
		begin
			passCount++;
			$display("test %s: passed", name);
		end
		else
		begin
			failCount++;
			$display("test %s: failed with %0d errors", name, errorCount - errBefore);
		end
		errBefore = errorCount;
	endtask

	initial
	begin
		nnPkg::actT sample [nnPkg::NumIn];
		nnPkg::actT allHigh [nnPkg::NumIn];
		nnPkg::actT allNeg [nnPkg::NumIn];
		int scores [nnPkg::NumClass];
		int cls;
		int best;
		int ties;
		logic found;

		seed = 2;
		reset = 1'b1;
		inValid = 1'b0;
		inAct = '0;
		outReady = 1'b1;
		checkLatency = 1'b0;
		cycleCount = 0;
		errorCount = 0;
		errBefore = 0;
		passCount = 0;
		failCount = 0;
		expValid = 1'b0;
		for (int i = 0; i < nnPkg::NumIn; i++)
		begin
			allHigh[i] = 8'd127;
			allNeg[i] = 8'd255;
		end
		applyReset();

		// Back to back at full rate.
		checkLatency = 1'b1;
		for (int s = 0; s < Test1Count; s++)
		begin
			randomSample(255, sample);
			sendSample(sample);
		end
		waitDrain();
		checkLatency = 1'b0;
		reportTest("backToBack");

		// Saturation, then a sample with every score clipped to zero if one exists.
		found = 1'b0;
		for (int t = 0; t < 3000 && !found; t++)
		begin
			randomSample(255, sample);
			modelScores(sample, scores);
			pickClass(scores, cls, best);
			found = (best == 0);
		end
		if (!found)
			sample = allNeg;
		sendSample(allHigh);
		sendSample(sample);
		sendSample(allNeg);
		waitDrain();
		reportTest("saturateAndRelu");

		// Two or more classes share the top score.
		found = 1'b0;
		for (int t = 0; t < 3000 && !found; t++)
		begin
			randomSample(127, sample);
			modelScores(sample, scores);
			pickClass(scores, cls, best);
			ties = 0;
			for (int c = 0; c < nnPkg::NumClass; c++)
				if (scores[c] == best)
					ties++;
			found = ties >= 2 && best > 0 && best < nnPkg::ActMax;
		end
		if (!found)
			sample = allHigh;
		sendSample(sample);
		waitDrain();
		reportTest("tieBreak");

		// Stall the consumer until the pipeline is full.
		outReady = 1'b0;
		for (int s = 0; s < StallCount; s++)
		begin
			randomSample(255, sample);
			sendSample(sample);
		end
		idleCycles(StallHold);
		fullStall: assert (!inReady && outValid)
			else
			begin
				$display("error at %0t: pipeline did not block input while stalled", $time);
				errorCount++;
			end
		outReady = 1'b1;
		for (int s = 0; s < 5; s++)
		begin
			randomSample(255, sample);
			sendSample(sample);
		end
		waitDrain();
		reportTest("backPressure");

		// Reset with samples stuck in the pipeline.
		outReady = 1'b0;
		for (int s = 0; s < ResetSamples; s++)
		begin
			randomSample(255, sample);
			sendSample(sample);
		end
		idleCycles(ResetIdle);
		applyReset();
		outReady = 1'b1;
		idleCycles(2);
		reportTest("resetBehavior");

		$display("tests passed %0d failed %0d, errors %0d", passCount, failCount, errorCount);
		if (errorCount == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== logic/mlpClassifier.sv ====
`timescale 1ns/1ps

module mlpClassifier #(
	parameter nnPkg::weightT [0:nnPkg::NumHidden*nnPkg::NumIn-1] HiddenWeights =
		nnPkg::DefHiddenWeights,
	parameter nnPkg::biasT [0:nnPkg::NumHidden-1] HiddenBias = nnPkg::DefHiddenBias,
	parameter nnPkg::weightT [0:nnPkg::NumClass*nnPkg::NumHidden-1] OutWeights =
		nnPkg::DefOutWeights,
	parameter nnPkg::biasT [0:nnPkg::NumClass-1] OutBias = nnPkg::DefOutBias
) (
	input logic clk,
	input logic reset,
	input logic inValid,
	output logic inReady,
	input nnPkg::actT [nnPkg::NumIn-1:0] inAct,
	output logic outValid,
	input logic outReady,
	output nnPkg::classT outClass,
	output nnPkg::actT outScore
);

	logic hidValid;
	logic hidReady;
	nnPkg::actT [nnPkg::NumHidden-1:0] hidAct;

	logic scoreValid;
	logic scoreReady;
	nnPkg::actT [nnPkg::NumClass-1:0] scoreAct;

	// Hidden layer, ten inputs to eight neurons.
	denseLayer #(
		.NumInputs(nnPkg::NumIn),
		.NumOutputs(nnPkg::NumHidden),
		.Weights(HiddenWeights),
		.Bias(HiddenBias)
	) uHidden (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inReady(inReady),
		.inAct(inAct),
		.outValid(hidValid),
		.outReady(hidReady),
		.outAct(hidAct)
	);

	// Output layer, one score per class.
	denseLayer #(
		.NumInputs(nnPkg::NumHidden),
		.NumOutputs(nnPkg::NumClass),
		.Weights(OutWeights),
		.Bias(OutBias)
	) uOutput (
		.clk(clk),
		.reset(reset),
		.inValid(hidValid),
		.inReady(hidReady),
		.inAct(hidAct),
		.outValid(scoreValid),
		.outReady(scoreReady),
		.outAct(scoreAct)
	);

	argmaxUnit #(
		.NumScores(nnPkg::NumClass)
	) uArgmax (
		.clk(clk),
		.reset(reset),
		.inValid(scoreValid),
		.inReady(scoreReady),
		.inAct(scoreAct),
		.outValid(outValid),
		.outReady(outReady),
		.outClass(outClass),
		.outScore(outScore)
	);

endmodule

// ==== logic/argmaxUnit.sv ====
`timescale 1ns/1ps

module argmaxUnit #(
	parameter int NumScores = 4
) (
	input logic clk,
	input logic reset,
	input logic inValid,
	output logic inReady,
	input nnPkg::actT [NumScores-1:0] inAct,
	output logic outValid,
	input logic outReady,
	output nnPkg::classT outClass,
	output nnPkg::actT outScore
);

	nnPkg::classT bestIdx;
	nnPkg::actT bestVal;

	// Strict compare, so the lowest index keeps a tie.
	always_comb
	begin
		bestIdx = '0;
		bestVal = inAct[0];
		for (int i = 1; i < NumScores; i++)
		begin
			if (inAct[i] > bestVal)
			begin
				bestIdx = nnPkg::classT'(i);
				bestVal = inAct[i];
			end
		end
	end

	assign inReady = !outValid || outReady;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			outValid <= 1'b0;
		end
		else if (inReady)
		begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (inValid && inReady)
		begin
			outClass <= bestIdx;
			outScore <= bestVal;
		end
	end

	classInRange: assert property (@(posedge clk) disable iff (reset)
		outValid |-> outClass < NumScores);

endmodule

// ==== logic/denseLayer.sv ====
`timescale 1ns/1ps

module denseLayer #(
	parameter int NumInputs = 10,
	parameter int NumOutputs = 8,
	parameter nnPkg::weightT [0:NumInputs*NumOutputs-1] Weights = '0,
	parameter nnPkg::biasT [0:NumOutputs-1] Bias = '0
) (
	input logic clk,
	input logic reset,
	input logic inValid,
	output logic inReady,
	input nnPkg::actT [NumInputs-1:0] inAct,
	output logic outValid,
	input logic outReady,
	output nnPkg::actT [NumOutputs-1:0] outAct
);

	// Stage 0 input register, stage 1 accumulator, stage 2 activation.
	logic [2:0] stageValid;
	logic advance;

	// The whole row moves together, or holds together.
	assign advance = !stageValid[2] || outReady;
	assign inReady = advance;
	assign outValid = stageValid[2];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			stageValid <= '0;
		end
		else if (advance)
		begin
			stageValid <= {stageValid[1:0], inValid};
		end
	end

	for (genvar n = 0; n < NumOutputs; n++)
	begin : gNeuron
		neuron #(
			.NumInputs(NumInputs),
			.Weights(Weights[n*NumInputs +: NumInputs]),
			.Bias(Bias[n])
		) uNeuron (
			.clk(clk),
			.reset(reset),
			.advance(advance),
			.act(inAct),
			.result(outAct[n])
		);
	end

	// A stalled output must not change until it is taken.
	outputHeld: assert property (@(posedge clk) disable iff (reset)
		outValid && !outReady |=> outValid && $stable(outAct));

endmodule

// ==== logic/neuron.sv ====
`timescale 1ns/1ps

module neuron #(
	parameter int NumInputs = 10,
	parameter nnPkg::weightT [0:NumInputs-1] Weights = '0,
	parameter nnPkg::biasT Bias = '0
) (
	input logic clk,
	input logic reset,
	input logic advance,
	input nnPkg::actT [NumInputs-1:0] act,
	output nnPkg::actT result
);

	// Integer bits of the result, seven for a limit of 127.
	localparam int IntBits = $clog2(nnPkg::ActMax + 1);
	localparam int SignBit = $bits(nnPkg::accT) - 1;
	localparam int TopBit = nnPkg::FracBits + IntBits;

	nnPkg::actT [NumInputs-1:0] actR;
	nnPkg::accT sum;
	nnPkg::accT accR;
	logic roundUp;
	logic [IntBits:0] rounded;
	nnPkg::actT activated;

	// Activations are read as signed, so inputs of 128 and up count negative.
	always_comb
	begin
		sum = nnPkg::accT'(Bias);
		for (int i = 0; i < NumInputs; i++)
		begin
			sum = sum + nnPkg::accT'(signed'(actR[i]) * Weights[i]);
		end
	end

	// Round up only when the dropped fraction is above one half.
	assign roundUp = accR[nnPkg::FracBits-1] && (|accR[nnPkg::FracBits-2:0]);
	assign rounded = {1'b0, accR[TopBit-1:nnPkg::FracBits]} + (IntBits+1)'(roundUp);

	always_comb
	begin
		if (accR[SignBit])
		begin
			activated = '0;
		end
		else if (|accR[SignBit-1:TopBit])
		begin
			activated = nnPkg::actT'(nnPkg::ActMax);
		end
		else if (rounded > nnPkg::ActMax)
		begin
			activated = nnPkg::actT'(nnPkg::ActMax);
		end
		else
		begin
			activated = nnPkg::actT'(rounded);
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actR <= '0;
			accR <= '0;
			result <= '0;
		end
		else if (advance)
		begin
			actR <= act;
			accR <= sum;
			result <= activated;
		end
	end

	// Result stays in range.
	resultInRange: assert property (@(posedge clk) disable iff (reset)
		result <= nnPkg::ActMax);

endmodule

// ==== logic/nnPkg.sv ====
package nnPkg;

	typedef logic [7:0] actT;
	typedef logic signed [7:0] weightT;
	typedef logic signed [15:0] biasT;
	typedef logic signed [22:0] accT;
	typedef logic [1:0] classT;

	localparam int FracBits = 6;
	localparam int ActMax = 127;

	localparam int NumIn = 10;
	localparam int NumHidden = 8;
	localparam int NumClass = 4;

	// Row n holds the weights of neuron n, one entry per input.
	localparam weightT [0:NumHidden*NumIn-1] DefHiddenWeights = '{
		8'sd62, 8'sd54, 8'sd50, -8'sd18, 8'sd44, 8'sd12, 8'sd4, 8'sd16, 8'sd4, -8'sd34,
		-8'sd22, 8'sd31, 8'sd8, 8'sd40, -8'sd15, 8'sd27, -8'sd9, 8'sd18, 8'sd33, -8'sd6,
		8'sd14, -8'sd37, 8'sd25, 8'sd9, 8'sd51, -8'sd12, 8'sd30, -8'sd20, 8'sd7, 8'sd22,
		8'sd35, 8'sd6, -8'sd28, 8'sd17, 8'sd3, 8'sd44, -8'sd16, 8'sd29, -8'sd11, 8'sd13,
		-8'sd8, 8'sd19, 8'sd41, -8'sd33, 8'sd26, 8'sd5, 8'sd38, -8'sd14, 8'sd21, 8'sd10,
		8'sd27, -8'sd5, 8'sd12, 8'sd48, -8'sd19, 8'sd16, 8'sd2, 8'sd36, -8'sd25, 8'sd31,
		8'sd9, 8'sd45, -8'sd17, 8'sd23, 8'sd11, -8'sd29, 8'sd52, 8'sd4, 8'sd18, -8'sd7,
		-8'sd31, 8'sd15, 8'sd20, 8'sd6, 8'sd39, 8'sd24, -8'sd10, 8'sd43, 8'sd1, 8'sd28
	};

	localparam biasT [0:NumHidden-1] DefHiddenBias = '{
		-16'sd1024, 16'sd256, -16'sd512, 16'sd128,
		-16'sd256, 16'sd384, -16'sd768, 16'sd64
	};

	localparam weightT [0:NumClass*NumHidden-1] DefOutWeights = '{
		8'sd24, -8'sd18, 8'sd33, 8'sd12, -8'sd9, 8'sd27, 8'sd15, -8'sd6,
		-8'sd11, 8'sd29, 8'sd8, 8'sd21, 8'sd30, -8'sd14, 8'sd19, 8'sd10,
		8'sd17, 8'sd13, -8'sd20, 8'sd35, 8'sd6, 8'sd22, -8'sd8, 8'sd26,
		8'sd32, 8'sd7, 8'sd14, -8'sd16, 8'sd25, 8'sd9, 8'sd28, -8'sd3
	};

	localparam biasT [0:NumClass-1] DefOutBias = '{
		-16'sd256, 16'sd128, -16'sd128, 16'sd64
	};

endpackage
